// File: gpio_apb_bridge.sv
`timescale 1ns/100ps

// APB phases to bank strobes
// no wait states, every transfer is setup plus access
module gpio_apb_bridge
(
  input  logic                 pclk24,
  input  logic                 n_reset24,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  gpio_pkg::apb_addr_t  paddr,   // bit 6 picks the bank
  input  gpio_pkg::gpio_data_t pwdata,
  input  gpio_pkg::gpio_data_t rdata_0, // bank 0 read data
  input  gpio_pkg::gpio_data_t rdata_1, // bank 1 read data
  output gpio_pkg::gpio_req_t  req_0,
  output gpio_pkg::gpio_req_t  req_1,
  output gpio_pkg::gpio_data_t prdata
);

  logic                 setup_phase;
  logic                 rd_strobe;   // setup phase read
  logic                 wr_strobe;   // access phase write
  logic                 bank_sel;    // 1 = bank 1
  logic                 rd_bank;     // bank captured at setup
  gpio_pkg::gpio_addr_t bank_addr;   // offset shared by both banks

  // --------------------
  // strobes
  // --------------------
  assign setup_phase = psel & ~penable;
  assign rd_strobe   = setup_phase & ~pwrite;      // bank samples its mux here
  assign wr_strobe   = psel & penable & pwrite;    // register loads at end of access
  assign bank_sel    = paddr[gpio_pkg::bank_sel_bit];
  assign bank_addr   = paddr[gpio_pkg::gpio_addr_width-1:0];

  // only the addressed bank sees a strobe
  always_comb
  begin
    req_0.read  = rd_strobe & ~bank_sel;
    req_0.write = wr_strobe & ~bank_sel;
    req_0.addr  = bank_addr;
    req_0.wdata = pwdata;

    req_1.read  = rd_strobe & bank_sel;
    req_1.write = wr_strobe & bank_sel;
    req_1.addr  = bank_addr;
    req_1.wdata = pwdata;
  end

  // --------------------
  // read return
  // --------------------
  // remember which bank was addressed in setup
  always_ff @(posedge pclk24 or negedge n_reset24)
  begin
    if (!n_reset24)
      rd_bank <= 1'b0;
    else if (setup_phase)
      rd_bank <= bank_sel;
  end

  // banks hold zero when not read, so prdata is 0 outside a read
  assign prdata = rd_bank ? rdata_1 : rdata_0;

endmodule

// File: gpio_input_sync.sv
`timescale 1ns/100ps

// pin synchronizer and sampled input register
// a pin change shows in input_value three clocks later
module gpio_input_sync
(
  input  logic                 pclk24,
  input  logic                 n_reset24,
  input  gpio_pkg::gpio_data_t pin_in,      // raw pads, async to pclk24
  output gpio_pkg::gpio_data_t input_value, // sampled input register
  output gpio_pkg::gpio_data_t int_event    // rising edge, one cycle early
);

  gpio_pkg::gpio_data_t s_synch_two; // first stage, next to the pad
  gpio_pkg::gpio_data_t s_synch;     // second stage

  // --------------------
  // sync chain
  // --------------------
  always_ff @(posedge pclk24 or negedge n_reset24)
  begin
    if (!n_reset24)
    begin
      s_synch_two <= '0;
      s_synch     <= '0;
      input_value <= gpio_pkg::gprv_input_value;
    end
    else
    begin
      s_synch_two <= pin_in;      // may go metastable
      s_synch     <= s_synch_two; // settled here
      input_value <= s_synch;     // what software reads
    end
  end

  // stage two already high while the register still holds 0
  // so the status bit lands on the same edge input_value rises
  assign int_event = s_synch & ~input_value;

endmodule

// File: gpio_lite.sv
`timescale 1ns/100ps

// two-bank, 32-pin GPIO with an APB slave port
module gpio_lite
(
  input  logic                 pclk24,
  input  logic                 n_reset24,
  // APB
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  gpio_pkg::apb_addr_t  paddr,
  input  gpio_pkg::gpio_data_t pwdata,
  output gpio_pkg::gpio_data_t prdata,
  // pads
  input  gpio_pkg::gpio_data_t pin_in_0,
  input  gpio_pkg::gpio_data_t pin_in_1,
  input  gpio_pkg::gpio_data_t tri_state_enable_0, // test mode Z
  input  gpio_pkg::gpio_data_t tri_state_enable_1,
  output gpio_pkg::gpio_pad_t  pad_0,
  output gpio_pkg::gpio_pad_t  pad_1,
  output gpio_pkg::gpio_data_t interrupt_0,
  output gpio_pkg::gpio_data_t interrupt_1
);

  gpio_pkg::gpio_req_t  req_0;   // bridge to bank 0
  gpio_pkg::gpio_req_t  req_1;   // bridge to bank 1
  gpio_pkg::gpio_data_t rdata_0;
  gpio_pkg::gpio_data_t rdata_1;

  // --------------------
  // bus side
  // --------------------
  gpio_apb_bridge u_bridge
  (
    .pclk24    (pclk24),
    .n_reset24 (n_reset24),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .rdata_0   (rdata_0),
    .rdata_1   (rdata_1),
    .req_0     (req_0),
    .req_1     (req_1),
    .prdata    (prdata)
  );

  // --------------------
  // banks
  // --------------------
  gpio_subunit u_bank_0
  (
    .pclk24           (pclk24),
    .n_reset24        (n_reset24),
    .req              (req_0),
    .pin_in           (pin_in_0),
    .tri_state_enable (tri_state_enable_0),
    .rdata            (rdata_0),
    .pad              (pad_0),
    .interrupt        (interrupt_0)
  );

  gpio_subunit u_bank_1 // paddr[6] = 1
  (
    .pclk24           (pclk24),
    .n_reset24        (n_reset24),
    .req              (req_1),
    .pin_in           (pin_in_1),
    .tri_state_enable (tri_state_enable_1),
    .rdata            (rdata_1),
    .pad              (pad_1),
    .interrupt        (interrupt_1)
  );

endmodule

// File: gpio_lite_tb.sv
`timescale 1ns/100ps

module gpio_lite_tb;

  typedef enum logic [2:0]
  {
    op_write,      // APB write, data from the table
    op_write_rand, // APB write, data from the LFSR
    op_read,       // APB read, expected prdata from the table
    op_read_model, // APB read, expected prdata from the model
    op_pins,       // new pins, then wait
    op_pins_rand,  // LFSR pins, then wait
    op_tse         // tri_state_enable from the pin columns
  } op_t;

  typedef struct packed {
    op_t                  op;
    gpio_pkg::apb_addr_t  addr;
    gpio_pkg::gpio_data_t wdata;
    gpio_pkg::gpio_data_t pins_0; // bank 0 pins
    gpio_pkg::gpio_data_t pins_1; // bank 1 pins
    gpio_pkg::gpio_data_t exp;    // expected prdata
  } row_t;

  localparam int pin_wait = 6; // input path plus status set

  logic                 pclk24 = 1'b0;
  logic                 n_reset24;
  logic                 psel;
  logic                 penable;
  logic                 pwrite;
  gpio_pkg::apb_addr_t  paddr;
  gpio_pkg::gpio_data_t pwdata;
  gpio_pkg::gpio_data_t prdata;
  gpio_pkg::gpio_data_t pin_in_0;
  gpio_pkg::gpio_data_t pin_in_1;
  gpio_pkg::gpio_data_t tri_state_enable_0;
  gpio_pkg::gpio_data_t tri_state_enable_1;
  gpio_pkg::gpio_pad_t  pad_0;
  gpio_pkg::gpio_pad_t  pad_1;
  gpio_pkg::gpio_data_t interrupt_0;
  gpio_pkg::gpio_data_t interrupt_1;

  // reference model, one entry per bank
  gpio_pkg::gpio_data_t m_dir [2];
  gpio_pkg::gpio_data_t m_oe [2];
  gpio_pkg::gpio_data_t m_ov [2];
  gpio_pkg::gpio_data_t m_inv [2];  // sampled pins
  gpio_pkg::gpio_data_t m_stat [2]; // pending rising edges
  gpio_pkg::gpio_data_t m_tse [2];

  row_t        rows [$];
  logic [31:0] lfsr_state = 32'h454eff79;
  int          read_errors = 0;
  int          output_errors = 0;
  int          cycle_count = 0;
  int          cycle_limit = 100000; // replaced once the table is built

  gpio_lite UUT
  (
    .pclk24             (pclk24),
    .n_reset24          (n_reset24),
    .psel               (psel),
    .penable            (penable),
    .pwrite             (pwrite),
    .paddr              (paddr),
    .pwdata             (pwdata),
    .prdata             (prdata),
    .pin_in_0           (pin_in_0),
    .pin_in_1           (pin_in_1),
    .tri_state_enable_0 (tri_state_enable_0),
    .tri_state_enable_1 (tri_state_enable_1),
    .pad_0              (pad_0),
    .pad_1              (pad_1),
    .interrupt_0        (interrupt_0),
    .interrupt_1        (interrupt_1)
  );

  always #50 pclk24 = ~pclk24; // 100 ns period

  // --------------------
  // timeout
  // --------------------
  always @(posedge pclk24)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit)
    begin
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("errors: %0d read, %0d output", read_errors, output_errors);
      $display("SOME TESTS FAILED");
      $finish;
    end
  end

  // galois step, taps for x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  task automatic draw_word(output gpio_pkg::gpio_data_t w);
    w = '0;
    for (int i = 0; i < gpio_pkg::gpio_width; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state); // one step per bit
      w = {w[gpio_pkg::gpio_width-2:0], lfsr_state[0]};
    end
  endtask

  // --------------------
  // model
  // --------------------
  task automatic model_write(input gpio_pkg::apb_addr_t a, input gpio_pkg::gpio_data_t d);
    int b;
    b = a[gpio_pkg::bank_sel_bit];
    case (a[5:0])
      gpio_pkg::gpr_direction_mode: m_dir[b] = d;
      gpio_pkg::gpr_output_enable:  m_oe[b] = d;
      gpio_pkg::gpr_output_value:   m_ov[b] = d;
      default: ; // read only or unmapped
    endcase
  endtask

  task automatic model_read(input gpio_pkg::apb_addr_t a, output gpio_pkg::gpio_data_t v);
    int b;
    b = a[gpio_pkg::bank_sel_bit];
    case (a[5:0])
      gpio_pkg::gpr_direction_mode: v = m_dir[b];
      gpio_pkg::gpr_output_enable:  v = m_oe[b];
      gpio_pkg::gpr_output_value:   v = m_ov[b];
      gpio_pkg::gpr_int_status:
      begin
        v = m_stat[b];
        m_stat[b] = '0; // clear on read
      end
      default: v = m_inv[b]; // input value, also for holes in the map
    endcase
  endtask

  task automatic model_pins(input int b, input gpio_pkg::gpio_data_t p);
    m_stat[b] = m_stat[b] | (m_dir[b] & p & ~m_inv[b]); // rising, input pins only
    m_inv[b]  = p;
  endtask

  // pin by pin, driven only when enabled, an output and not forced to Z
  function automatic gpio_pkg::gpio_data_t expected_oe_n(input int b);
    gpio_pkg::gpio_data_t v;
    for (int i = 0; i < gpio_pkg::gpio_width; i++)
      v[i] = (m_oe[b][i] && !m_dir[b][i] && !m_tse[b][i]) ? 1'b0 : 1'b1;
    return v;
  endfunction

  // --------------------
  // checks
  // --------------------
  task automatic check_word(input string name, input gpio_pkg::gpio_data_t exp,
                            input gpio_pkg::gpio_data_t act, input bit on_bus);
    assert (act === exp)
    else
    begin
      $display("CHECK FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
      if (on_bus)
        read_errors++;
      else
        output_errors++;
    end
  endtask

  task automatic check_outputs;
    check_word("pad_0.pin_out", m_ov[0], pad_0.pin_out, 1'b0);
    check_word("pad_0.pin_oe_n", expected_oe_n(0), pad_0.pin_oe_n, 1'b0);
    check_word("pad_1.pin_out", m_ov[1], pad_1.pin_out, 1'b0);
    check_word("pad_1.pin_oe_n", expected_oe_n(1), pad_1.pin_oe_n, 1'b0);
    check_word("interrupt_0", m_stat[0], interrupt_0, 1'b0);
    check_word("interrupt_1", m_stat[1], interrupt_1, 1'b0);
    check_word("prdata", 16'h0000, prdata, 1'b1); // idle bus reads zero
  endtask

  // --------------------
  // APB
  // --------------------
  task automatic apb_write(input gpio_pkg::apb_addr_t a, input gpio_pkg::gpio_data_t d);
    @(posedge pclk24); // setup
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= a;
    pwdata  <= d;
    @(posedge pclk24); // access
    penable <= 1'b1;
    @(posedge pclk24); // register loads here
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_read(input gpio_pkg::apb_addr_t a, input gpio_pkg::gpio_data_t exp);
    @(posedge pclk24); // setup, bank samples its mux
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= a;
    @(posedge pclk24);
    penable <= 1'b1;
    @(negedge pclk24); // mid access, prdata settled
    check_word("prdata", exp, prdata, 1'b1);
    @(posedge pclk24);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic run_row(input row_t r);
    gpio_pkg::gpio_data_t data;
    gpio_pkg::gpio_data_t p0;
    gpio_pkg::gpio_data_t p1;
    gpio_pkg::gpio_data_t exp;
    data = r.wdata;
    p0   = r.pins_0;
    p1   = r.pins_1;
    case (r.op)
      op_write, op_write_rand:
      begin
        if (r.op == op_write_rand)
          draw_word(data);
        apb_write(r.addr, data);
        model_write(r.addr, data);
      end
      op_read, op_read_model:
      begin
        model_read(r.addr, exp); // keeps model clears in step
        if (r.op == op_read)
          exp = r.exp;
        apb_read(r.addr, exp);
      end
      op_pins, op_pins_rand:
      begin
        if (r.op == op_pins_rand)
        begin
          draw_word(p0);
          draw_word(p1);
        end
        @(posedge pclk24);
        pin_in_0 <= p0;
        pin_in_1 <= p1;
        model_pins(0, p0);
        model_pins(1, p1);
        repeat (pin_wait) @(posedge pclk24);
      end
      default: // op_tse
      begin
        @(posedge pclk24);
        tri_state_enable_0 <= p0;
        tri_state_enable_1 <= p1;
        m_tse[0] = p0;
        m_tse[1] = p1;
      end
    endcase
  endtask

  task automatic add_row(input op_t op, input gpio_pkg::apb_addr_t addr,
                         input gpio_pkg::gpio_data_t wdata, input gpio_pkg::gpio_data_t p0,
                         input gpio_pkg::gpio_data_t p1, input gpio_pkg::gpio_data_t exp);
    row_t r;
    r = {op, addr, wdata, p0, p1, exp};
    rows.push_back(r);
  endtask

  // --------------------
  // table
  // --------------------
  task automatic build_table;
    // reset values
    add_row(op_read, 7'h04, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_read, 7'h08, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_read, 7'h0C, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_read, 7'h10, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_read, 7'h20, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_read, 7'h44, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_read, 7'h48, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_read, 7'h4C, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_read, 7'h50, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_read, 7'h60, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
    // write and readback, bank 1 leaves bank 0 alone
    add_row(op_write, 7'h0C, 16'hA5A5, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_write, 7'h08, 16'h00FF, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_read, 7'h0C, 16'h0000, 16'h0000, 16'h0000, 16'hA5A5);
    add_row(op_write, 7'h4C, 16'h1234, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_write, 7'h48, 16'hFFFF, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_write, 7'h44, 16'h0F0F, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_read, 7'h4C, 16'h0000, 16'h0000, 16'h0000, 16'h1234);
    add_row(op_read, 7'h44, 16'h0000, 16'h0000, 16'h0000, 16'h0F0F);
    add_row(op_read, 7'h0C, 16'h0000, 16'h0000, 16'h0000, 16'hA5A5);
    add_row(op_read, 7'h08, 16'h0000, 16'h0000, 16'h0000, 16'h00FF);
    // test tri-state overrides the drivers
    add_row(op_tse, 7'h00, 16'h0000, 16'h00F0, 16'hFFFF, 16'h0000);
    add_row(op_tse, 7'h00, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
    // pins in, upper byte of bank 0 as inputs
    add_row(op_write, 7'h04, 16'hFF00, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_pins, 7'h00, 16'h0000, 16'hF00F, 16'h3C3C, 16'h0000);
    add_row(op_read, 7'h10, 16'h0000, 16'h0000, 16'h0000, 16'hF00F);
    add_row(op_read, 7'h7C, 16'h0000, 16'h0000, 16'h0000, 16'h3C3C); // unmapped
    // interrupts, clear on read
    add_row(op_read, 7'h20, 16'h0000, 16'h0000, 16'h0000, 16'hF000);
    add_row(op_read, 7'h20, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_read, 7'h60, 16'h0000, 16'h0000, 16'h0000, 16'h0C0C);
    add_row(op_pins, 7'h00, 16'h0000, 16'h0000, 16'h0000, 16'h0000); // falling
    add_row(op_read, 7'h60, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
    add_row(op_pins, 7'h00, 16'h0000, 16'hFFFF, 16'hFFFF, 16'h0000);
    add_row(op_read, 7'h20, 16'h0000, 16'h0000, 16'h0000, 16'hFF00);
    add_row(op_read, 7'h60, 16'h0000, 16'h0000, 16'h0000, 16'h0F0F);
    // random rows, expectations from the model
    for (int i = 0; i < 3; i++)
    begin
      add_row(op_write_rand, 7'h04, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
      add_row(op_write_rand, 7'h44, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
      add_row(op_write_rand, 7'h0C, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
      add_row(op_pins_rand, 7'h00, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
      add_row(op_read_model, 7'h20, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
      add_row(op_read_model, 7'h60, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
      add_row(op_read_model, 7'h50, 16'h0000, 16'h0000, 16'h0000, 16'h0000);
    end
  endtask

  initial
  begin
    n_reset24          = 1'b0;
    psel               = 1'b0;
    penable            = 1'b0;
    pwrite             = 1'b0;
    paddr              = '0;
    pwdata             = '0;
    pin_in_0           = '0;
    pin_in_1           = '0;
    tri_state_enable_0 = '0;
    tri_state_enable_1 = '0;
    for (int b = 0; b < 2; b++)
    begin
      m_dir[b]  = '0;
      m_oe[b]   = '0;
      m_ov[b]   = '0;
      m_inv[b]  = '0;
      m_stat[b] = '0;
      m_tse[b]  = '0;
    end
    build_table();
    cycle_limit = rows.size() * 8 + 64;
    repeat (16) @(posedge pclk24);
    n_reset24 <= 1'b1;
    @(negedge pclk24);
    check_outputs(); // state after reset
    foreach (rows[i])
    begin
      run_row(rows[i]);
      @(negedge pclk24);
      check_outputs();
    end
    $display("errors: %0d read, %0d output", read_errors, output_errors);
    if (read_errors + output_errors == 0)
      $display("ALL TESTS PASSED");
    else
      $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

// File: gpio_pkg.sv
package gpio_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int gpio_width      = 16; // pins per bank
  localparam int gpio_addr_width = 6;  // in-bank register address
  localparam int apb_addr_width  = 7;  // in-bank address plus bank select
  localparam int bank_sel_bit    = 6;  // paddr bit that picks the bank

  typedef logic [gpio_width-1:0]      gpio_data_t; // pin, data and register words
  typedef logic [gpio_addr_width-1:0] gpio_addr_t; // register offset inside a bank
  typedef logic [apb_addr_width-1:0]  apb_addr_t;  // full APB address

  // --------------------
  // register map
  // --------------------
  localparam gpio_addr_t gpr_direction_mode = 6'h04; // 1 = input, 0 = output
  localparam gpio_addr_t gpr_output_enable  = 6'h08; // output driver on
  localparam gpio_addr_t gpr_output_value   = 6'h0C; // value sent to the pad
  localparam gpio_addr_t gpr_input_value    = 6'h10; // sampled pins, read only
  localparam gpio_addr_t gpr_int_status     = 6'h20; // rising-edge status, clear on read

  // reset values
  localparam gpio_data_t gprv_direction_mode = '0; // all pins outputs
  localparam gpio_data_t gprv_output_enable  = '0; // drivers off
  localparam gpio_data_t gprv_output_value   = '0;
  localparam gpio_data_t gprv_input_value    = '0;
  localparam gpio_data_t gprv_int_status     = '0; // nothing pending

  // --------------------
  // bundles
  // --------------------

  // bridge to bank, one per bank
  typedef struct packed {
    logic       read;  // setup-phase strobe
    logic       write; // access-phase strobe
    gpio_addr_t addr;
    gpio_data_t wdata;
  } gpio_req_t;

  // pad side of one bank
  typedef struct packed {
    gpio_data_t pin_out;  // value to the pad
    gpio_data_t pin_oe_n; // driver enable, active low
  } gpio_pad_t;

endpackage

// File: gpio_subunit.sv
`timescale 1ns/100ps

// one 16-pin GPIO bank
// control registers, rising-edge interrupt status and pad drive
module gpio_subunit
(
  input  logic                 pclk24,
  input  logic                 n_reset24,
  input  gpio_pkg::gpio_req_t  req,              // strobes, addr, wdata from the bridge
  input  gpio_pkg::gpio_data_t pin_in,           // pads in
  input  gpio_pkg::gpio_data_t tri_state_enable, // test input, forces pads to Z
  output gpio_pkg::gpio_data_t rdata,            // registered read data
  output gpio_pkg::gpio_pad_t  pad,              // pad drive
  output gpio_pkg::gpio_data_t interrupt         // one line per pin
);

  // software visible registers
  gpio_pkg::gpio_data_t direction_mode; // 1 = input
  gpio_pkg::gpio_data_t output_enable;
  gpio_pkg::gpio_data_t output_value;
  gpio_pkg::gpio_data_t input_value;    // from the sync block
  gpio_pkg::gpio_data_t int_status;

  gpio_pkg::gpio_data_t int_event;         // rising edge seen
  gpio_pkg::gpio_data_t interrupt_trigger; // events on input pins only
  gpio_pkg::gpio_data_t status_clear;      // whole vector on a status read

  logic ad_direction_mode;
  logic ad_output_enable;
  logic ad_output_value;
  logic ad_int_status;

  // --------------------
  // input path
  // --------------------
  gpio_input_sync u_input_sync
  (
    .pclk24      (pclk24),
    .n_reset24   (n_reset24),
    .pin_in      (pin_in),
    .input_value (input_value),
    .int_event   (int_event)
  );

  // --------------------
  // address decode
  // --------------------
  assign ad_direction_mode = (req.addr == gpio_pkg::gpr_direction_mode);
  assign ad_output_enable  = (req.addr == gpio_pkg::gpr_output_enable);
  assign ad_output_value   = (req.addr == gpio_pkg::gpr_output_value);
  assign ad_int_status     = (req.addr == gpio_pkg::gpr_int_status);

  // write side
  always_ff @(posedge pclk24 or negedge n_reset24)
  begin
    if (!n_reset24)
    begin
      direction_mode <= gpio_pkg::gprv_direction_mode;
      output_enable  <= gpio_pkg::gprv_output_enable;
      output_value   <= gpio_pkg::gprv_output_value;
    end
    else if (req.write)
    begin
      if (ad_direction_mode)
        direction_mode <= req.wdata;
      if (ad_output_enable)
        output_enable <= req.wdata;
      if (ad_output_value)
        output_value <= req.wdata;
      // input_value and int_status ignore writes
    end
  end

  // --------------------
  // interrupt status
  // --------------------
  assign interrupt_trigger = direction_mode & int_event; // output pins never flag
  assign status_clear      = {gpio_pkg::gpio_width{req.read & ad_int_status}};

  always_ff @(posedge pclk24 or negedge n_reset24)
  begin
    if (!n_reset24)
      int_status <= gpio_pkg::gprv_int_status;
    else
      int_status <= (int_status & ~status_clear) | interrupt_trigger; // new event beats clear
  end

  assign interrupt = int_status;

  // --------------------
  // read mux
  // --------------------
  // sampled on the setup-phase strobe, held for the access phase
  always_ff @(posedge pclk24 or negedge n_reset24)
  begin
    if (!n_reset24)
      rdata <= '0;
    else if (req.read)
    begin
      case (req.addr)
        gpio_pkg::gpr_direction_mode:
          rdata <= direction_mode;
        gpio_pkg::gpr_output_enable:
          rdata <= output_enable;
        gpio_pkg::gpr_output_value:
          rdata <= output_value;
        gpio_pkg::gpr_int_status:
          rdata <= int_status;    // value before the clear
        default:
          rdata <= input_value;   // gpr_input_value and unmapped
      endcase
    end
    else
      rdata <= '0;                // zero outside a read, bridge relies on it
  end

  // pad drive
  assign pad.pin_out  = output_value;
  assign pad.pin_oe_n = ~(output_enable & ~direction_mode) | tri_state_enable;

endmodule

// File: src.f
gpio_pkg.sv
gpio_input_sync.sv
gpio_subunit.sv
gpio_apb_bridge.sv
gpio_lite.sv
gpio_lite_tb.sv
